/* Makefile */
VERILATOR ?= verilator
TOP       ?= regReadTb
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' compile.f) tb/regReadModel.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): compile.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
+incdir+tb
source/regReadPkg.sv
source/issueFilter.sv
source/physRegFile.sv
source/operandBypass.sv
source/regReadyTable.sv
source/regReadStage.sv
tb/regReadTb.sv

/* source/issueFilter.sv */
`default_nettype none

module issueFilter #(
  parameter int NumLanes = 4
) (
  input  regReadPkg::issuePktT [NumLanes-1:0] issuePkt_i,
  input  regReadPkg::squashT                  squash_i,
  output regReadPkg::issuePktT [NumLanes-1:0] filtered_o,
  output regReadPkg::readReqT  [NumLanes-1:0] readReq_o
);

  logic [NumLanes-1:0] squashHit;  // lane sits behind the mispredicted branch

  // a lane dies when it was issued under the checkpoint that just mispredicted
  always_comb begin
    for (int l = 0; l < NumLanes; l++) begin
      squashHit[l] = squash_i.valid && issuePkt_i[l].branchMask[squash_i.ckptId];
    end
  end

  always_comb begin
    for (int l = 0; l < NumLanes; l++) begin
      filtered_o[l]       = issuePkt_i[l];
      filtered_o[l].valid = issuePkt_i[l].valid && !squashHit[l];
    end
  end

  // the register file is read for every lane, squashed or not
  always_comb begin
    for (int l = 0; l < NumLanes; l++) begin
      readReq_o[l].src1Tag = issuePkt_i[l].src1Tag;
      readReq_o[l].src2Tag = issuePkt_i[l].src2Tag;
    end
  end

endmodule

`default_nettype wire

/* source/operandBypass.sv */
`default_nettype none

module operandBypass #(
  parameter int NumLanes = 4
) (
  input  wire                                  clk,
  input  wire                                  rstN_i,
  input  regReadPkg::issuePktT  [NumLanes-1:0] filtered_i,
  input  regReadPkg::readDataT  [NumLanes-1:0] readData_i,
  input  regReadPkg::bypassPktT [NumLanes-1:0] bypass_i,
  output regReadPkg::outPktT    [NumLanes-1:0] outPkt_o
);

  regReadPkg::outPktT [NumLanes-1:0] nextPkt;
  regReadPkg::outPktT [NumLanes-1:0] outQ;
  logic [NumLanes-1:0]               outValid;

  // bypass data wins only on a single clean match, anything else reads the array
  function automatic regReadPkg::dataT pickOperand(
    input regReadPkg::physTagT                  tag,
    input regReadPkg::dataT                     rfData,
    input regReadPkg::bypassPktT [NumLanes-1:0] bypass
  );
    logic [NumLanes-1:0] match;
    regReadPkg::dataT    bypData;
    logic                oneHot;
    match   = '0;
    bypData = '0;
    for (int k = 0; k < NumLanes; k++) begin
      match[k] = bypass[k].valid && (bypass[k].tag == tag);
      if (match[k]) begin
        bypData = bypData | bypass[k].data;  // or-mux, only used when one-hot
      end
    end
    oneHot = (match != '0) && ((match & (match - 1'b1)) == '0);
    return oneHot ? bypData : rfData;
  endfunction

  always_comb begin
    for (int l = 0; l < NumLanes; l++) begin
      nextPkt[l].valid      = filtered_i[l].valid;
      nextPkt[l].branchMask = filtered_i[l].branchMask;
      nextPkt[l].src1Tag    = filtered_i[l].src1Tag;
      nextPkt[l].src2Tag    = filtered_i[l].src2Tag;
      nextPkt[l].destTag    = filtered_i[l].destTag;
      nextPkt[l].opcode     = filtered_i[l].opcode;
      nextPkt[l].immediate  = filtered_i[l].immediate;
      nextPkt[l].data1      = pickOperand(filtered_i[l].src1Tag, readData_i[l].data1, bypass_i);
      nextPkt[l].data2      = pickOperand(filtered_i[l].src2Tag, readData_i[l].data2, bypass_i);
    end
  end

  // pipeline register toward execute, payload just holds during reset
  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      for (int l = 0; l < NumLanes; l++) begin
        outQ[l].valid <= 1'b0;
      end
    end else begin
      outQ <= nextPkt;
    end
  end

  always_comb begin
    for (int l = 0; l < NumLanes; l++) begin
      outValid[l] = outQ[l].valid;
    end
  end

  assign outPkt_o = outQ;

  // execute must not see a stale instruction right after reset
  assert property (@(posedge clk) !rstN_i |=> (outValid == '0))
    else $error("output valid set in the cycle after reset: %b", outValid);

endmodule

`default_nettype wire

/* source/physRegFile.sv */
`default_nettype none

module physRegFile #(
  parameter int NumLanes = 4
) (
  input  wire                                  clk,
  input  wire                                  rstN_i,
  input  regReadPkg::readReqT   [NumLanes-1:0] readReq_i,
  input  regReadPkg::bypassPktT [NumLanes-1:0] bypass_i,
  input  wire                                  recover_i,
  output regReadPkg::readDataT  [NumLanes-1:0] readData_o
);

  regReadPkg::dataT    regFile [regReadPkg::PhysRegs];
  logic [NumLanes-1:0] wrEn;

  // results of a recovering cycle belong to the wrong path and are not kept
  always_comb begin
    for (int l = 0; l < NumLanes; l++) begin
      wrEn[l] = bypass_i[l].valid && !recover_i;
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < NumLanes; l++) begin
      if (wrEn[l]) begin
        regFile[bypass_i[l].tag] <= bypass_i[l].data;
      end
    end
  end

  // reads see the array before this cycle's writes, bypass covers the rest
  always_comb begin
    for (int l = 0; l < NumLanes; l++) begin
      readData_o[l].data1 = regFile[readReq_i[l].src1Tag];
      readData_o[l].data2 = regFile[readReq_i[l].src2Tag];
    end
  end

  // rename never hands one tag to two producers, so two writers per tag means
  // the free list or the bypass network upstream is broken
  for (genvar i = 0; i < NumLanes; i++) begin : gWrA
    for (genvar j = i + 1; j < NumLanes; j++) begin : gWrB
      assert property (@(posedge clk) disable iff (!rstN_i)
        !(wrEn[i] && wrEn[j] && (bypass_i[i].tag == bypass_i[j].tag)))
        else $error("lanes %0d and %0d write tag %0d together", i, j, bypass_i[i].tag);
    end
  end

endmodule

`default_nettype wire

/* source/regReadPkg.sv */
`default_nettype none

package regReadPkg;

  localparam int PhysRegs    = 64;
  localparam int ArchRegs    = 32;  // tags below this hold committed state after reset
  localparam int DataWidth   = 32;
  localparam int Checkpoints = 4;

  typedef logic [$clog2(PhysRegs)-1:0]    physTagT;
  typedef logic [DataWidth-1:0]           dataT;
  typedef logic [$clog2(Checkpoints)-1:0] ckptIdT;

  // instruction as it leaves the issue queue
  typedef struct packed {
    logic                   valid;
    logic [Checkpoints-1:0] branchMask;  // one bit per unresolved branch it depends on
    physTagT                src1Tag;
    physTagT                src2Tag;
    physTagT                destTag;
    logic [7:0]             opcode;
    logic [15:0]            immediate;
  } issuePktT;

  typedef struct packed {
    logic    valid;
    physTagT tag;
    dataT    data;
  } bypassPktT;

  typedef struct packed {
    physTagT src1Tag;
    physTagT src2Tag;
  } readReqT;

  typedef struct packed {
    dataT data1;
    dataT data2;
  } readDataT;

  typedef struct packed {
    logic    valid;
    physTagT tag;
  } unmapReqT;

  typedef struct packed {
    logic    valid;
    physTagT tag;
  } wakeupT;

  typedef struct packed {
    logic   valid;
    ckptIdT ckptId;
  } squashT;

  // issue packet with both operands attached
  typedef struct packed {
    logic                   valid;
    logic [Checkpoints-1:0] branchMask;
    physTagT                src1Tag;
    physTagT                src2Tag;
    physTagT                destTag;
    logic [7:0]             opcode;
    logic [15:0]            immediate;
    dataT                   data1;
    dataT                   data2;
  } outPktT;

endpackage

`default_nettype wire

/* source/regReadStage.sv */
`default_nettype none

module regReadStage #(
  parameter int NumLanes = 4
) (
  input  wire                                  clk,
  input  wire                                  rstN_i,
  input  regReadPkg::issuePktT  [NumLanes-1:0] issuePkt_i,
  input  regReadPkg::bypassPktT [NumLanes-1:0] bypass_i,
  input  regReadPkg::unmapReqT  [NumLanes-1:0] unmap_i,
  input  regReadPkg::wakeupT    [NumLanes-1:0] wakeup_i,
  input  regReadPkg::squashT                   squash_i,
  input  wire                                  recover_i,
  input  wire                                  exception_i,
  output regReadPkg::outPktT    [NumLanes-1:0] outPkt_o,
  output logic [regReadPkg::PhysRegs-1:0]      phyRegRdy_o
);

  regReadPkg::issuePktT [NumLanes-1:0] filtered;
  regReadPkg::readReqT  [NumLanes-1:0] readReq;
  regReadPkg::readDataT [NumLanes-1:0] readData;

  issueFilter #(
    .NumLanes(NumLanes)
  ) issueFilter_i (
    .issuePkt_i(issuePkt_i),
    .squash_i  (squash_i),
    .filtered_o(filtered),
    .readReq_o (readReq)
  );

  physRegFile #(
    .NumLanes(NumLanes)
  ) physRegFile_i (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .readReq_i (readReq),
    .bypass_i  (bypass_i),
    .recover_i (recover_i),
    .readData_o(readData)
  );

  operandBypass #(
    .NumLanes(NumLanes)
  ) operandBypass_i (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .filtered_i(filtered),
    .readData_i(readData),
    .bypass_i  (bypass_i),
    .outPkt_o  (outPkt_o)
  );

  // ready bits run on their own, next to the datapath
  regReadyTable #(
    .NumLanes(NumLanes)
  ) regReadyTable_i (
    .clk        (clk),
    .rstN_i     (rstN_i),
    .exception_i(exception_i),
    .unmap_i    (unmap_i),
    .wakeup_i   (wakeup_i),
    .phyRegRdy_o(phyRegRdy_o)
  );

endmodule

`default_nettype wire

/* source/regReadyTable.sv */
`default_nettype none

module regReadyTable #(
  parameter int NumLanes = 4
) (
  input  wire                                     clk,
  input  wire                                     rstN_i,
  input  wire                                     exception_i,
  input  regReadPkg::unmapReqT [NumLanes-1:0]     unmap_i,
  input  regReadPkg::wakeupT   [NumLanes-1:0]     wakeup_i,
  output logic [regReadPkg::PhysRegs-1:0]         phyRegRdy_o
);

  localparam int PhysRegs = regReadPkg::PhysRegs;
  localparam int ArchRegs = regReadPkg::ArchRegs;

  // architectural mappings start out ready, the free pool starts not ready
  localparam logic [PhysRegs-1:0] ResetPattern =
    {{(PhysRegs - ArchRegs){1'b0}}, {ArchRegs{1'b1}}};

  logic [PhysRegs-1:0] rdyQ;
  logic [PhysRegs-1:0] rdyNext;

  always_comb begin
    rdyNext = rdyQ;
    for (int l = 0; l < NumLanes; l++) begin
      if (unmap_i[l].valid) begin
        rdyNext[unmap_i[l].tag] = 1'b0;
      end
    end
    // applied second, so a result for a freshly unmapped tag still counts
    for (int l = 0; l < NumLanes; l++) begin
      if (wakeup_i[l].valid) begin
        rdyNext[wakeup_i[l].tag] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i || exception_i) begin
      rdyQ <= ResetPattern;
    end else begin
      rdyQ <= rdyNext;
    end
  end

  assign phyRegRdy_o = rdyQ;

endmodule

`default_nettype wire

/* tb/regReadModel.svh */
`ifndef REG_READ_MODEL_SVH
`define REG_READ_MODEL_SVH

typedef regReadPkg::outPktT    [Lanes-1:0] outVecT;
typedef regReadPkg::issuePktT  [Lanes-1:0] issueVecT;
typedef regReadPkg::bypassPktT [Lanes-1:0] bypassVecT;
typedef regReadPkg::unmapReqT  [Lanes-1:0] unmapVecT;
typedef regReadPkg::wakeupT    [Lanes-1:0] wakeupVecT;

regReadPkg::dataT                shadowRf [regReadPkg::PhysRegs];
logic [regReadPkg::PhysRegs-1:0] shadowRdy;

// architectural registers come out of reset ready, the free pool does not
function automatic logic [regReadPkg::PhysRegs-1:0] readyAfterReset();
  logic [regReadPkg::PhysRegs-1:0] rdy;
  for (int t = 0; t < regReadPkg::PhysRegs; t++) begin
    rdy[t] = (t < regReadPkg::ArchRegs);
  end
  return rdy;
endfunction

function automatic regReadPkg::dataT expectOperand(input regReadPkg::physTagT tag,
                                                   input bypassVecT byp);
  int               hits;
  regReadPkg::dataT hitData;
  hits    = 0;
  hitData = '0;
  for (int k = 0; k < Lanes; k++) begin
    if (byp[k].valid && byp[k].tag == tag) begin
      hits++;
      hitData = byp[k].data;
    end
  end
  if (hits == 1) begin
    return hitData;
  end
  return shadowRf[tag];  // stale array content when bypass is absent or ambiguous
endfunction

function automatic outVecT expectPackets(input issueVecT iss, input regReadPkg::squashT sq,
                                         input bypassVecT byp);
  outVecT pkts;
  for (int l = 0; l < Lanes; l++) begin
    pkts[l].valid      = iss[l].valid && !(sq.valid && iss[l].branchMask[sq.ckptId]);
    pkts[l].branchMask = iss[l].branchMask;
    pkts[l].src1Tag    = iss[l].src1Tag;
    pkts[l].src2Tag    = iss[l].src2Tag;
    pkts[l].destTag    = iss[l].destTag;
    pkts[l].opcode     = iss[l].opcode;
    pkts[l].immediate  = iss[l].immediate;
    pkts[l].data1      = expectOperand(iss[l].src1Tag, byp);
    pkts[l].data2      = expectOperand(iss[l].src2Tag, byp);
  end
  return pkts;
endfunction

// advance the shadow state by one clock edge
function automatic void updateModel(input bypassVecT byp, input logic recover,
                                    input logic exception, input unmapVecT unm,
                                    input wakeupVecT wk);
  for (int k = 0; k < Lanes; k++) begin
    if (byp[k].valid && !recover) begin
      shadowRf[byp[k].tag] = byp[k].data;
    end
  end
  if (exception) begin
    shadowRdy = readyAfterReset();
  end else begin
    for (int k = 0; k < Lanes; k++) begin
      if (unm[k].valid) shadowRdy[unm[k].tag] = 1'b0;
    end
    for (int k = 0; k < Lanes; k++) begin
      if (wk[k].valid) shadowRdy[wk[k].tag] = 1'b1;  // wakeup beats unmap
    end
  end
endfunction

`endif

/* tb/regReadTb.sv */
`default_nettype none

module regReadTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int Lanes = 4;

  `include "regReadModel.svh"

  typedef struct packed {
    logic [3:0]  bypV;
    logic [5:0]  bypBase;  // lane l uses bypBase + l, so lanes never share a tag
    logic [3:0]  issV;
    logic [5:0]  srcA;
    logic [5:0]  srcB;
    logic [15:0] bMask;    // four bits per lane
    logic        sqV;
    logic [1:0]  sqCk;
    logic        recover;
    logic        exception;
    logic [3:0]  unmV;
    logic [5:0]  unmBase;
    logic [3:0]  wkV;
    logic [5:0]  wkBase;
  } stepT;

  localparam int NumSteps = 17;

  // bypV bypBase issV srcA srcB bMask sqV sqCk rec exc unmV unmBase wkV wkBase
  localparam stepT Steps [NumSteps] = '{
    '{4'h0, 6'd0, 4'hf, 6'd0, 6'd12, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b0, 4'h0, 6'd0, 4'h0, 6'd0},
    '{4'h0, 6'd0, 4'hf, 6'd48, 6'd60, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b0, 4'h0, 6'd0, 4'h0, 6'd0},
    '{4'hf, 6'd8, 4'hf, 6'd8, 6'd20, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b0, 4'h0, 6'd0, 4'h0, 6'd0},
    '{4'h0, 6'd0, 4'hf, 6'd8, 6'd10, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b0, 4'h0, 6'd0, 4'h0, 6'd0},
    '{4'h5, 6'd16, 4'hf, 6'd16, 6'd18, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b0, 4'h0, 6'd0, 4'h0, 6'd0},
    '{4'hf, 6'd40, 4'hf, 6'd40, 6'd44, 16'h0000, 1'b0, 2'd0, 1'b1, 1'b0, 4'h0, 6'd0, 4'h0, 6'd0},
    '{4'h0, 6'd0, 4'hf, 6'd40, 6'd42, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b0, 4'h0, 6'd0, 4'h0, 6'd0},
    '{4'h0, 6'd0, 4'hf, 6'd4, 6'd8, 16'h8421, 1'b1, 2'd2, 1'b0, 1'b0, 4'h0, 6'd0, 4'h0, 6'd0},
    '{4'hf, 6'd4, 4'hb, 6'd4, 6'd6, 16'h1111, 1'b1, 2'd0, 1'b0, 1'b0, 4'h0, 6'd0, 4'h0, 6'd0},
    '{4'h0, 6'd0, 4'h0, 6'd0, 6'd0, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b0, 4'hf, 6'd0, 4'h0, 6'd0},
    '{4'h0, 6'd0, 4'h0, 6'd0, 6'd0, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b0, 4'h0, 6'd0, 4'hf, 6'd40},
    '{4'h0, 6'd0, 4'h0, 6'd0, 6'd0, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b0, 4'hf, 6'd40, 4'h3, 6'd41},
    '{4'h0, 6'd0, 4'h0, 6'd0, 6'd0, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b1, 4'hf, 6'd4, 4'hf, 6'd50},
    '{4'h0, 6'd0, 4'h0, 6'd0, 6'd0, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b0, 4'hf, 6'd28, 4'hf, 6'd60},
    '{4'h0, 6'd0, 4'hf, 6'd20, 6'd30, 16'h0777, 1'b1, 2'd3, 1'b0, 1'b0, 4'h0, 6'd0, 4'h0, 6'd0},
    '{4'hf, 6'd60, 4'hf, 6'd62, 6'd58, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b0, 4'h0, 6'd0, 4'h0, 6'd0},
    '{4'h0, 6'd0, 4'h0, 6'd0, 6'd0, 16'h0000, 1'b0, 2'd0, 1'b0, 1'b0, 4'h0, 6'd0, 4'h0, 6'd0}
  };

  logic                            clk;
  logic                            rstN;
  issueVecT                        issuePkt;
  bypassVecT                       bypass;
  unmapVecT                        unmap;
  wakeupVecT                       wakeup;
  regReadPkg::squashT              squash;
  logic                            recover;
  logic                            exception;
  outVecT                          outPkt;
  logic [regReadPkg::PhysRegs-1:0] phyRegRdy;

  outVecT      expPkt;
  logic        haveExp;    // payload fields are known once a step was applied
  logic        expFull;    // operands are known once every register was written
  int          errCount;
  int          checkCount;
  logic [31:0] rngState = 32'hae626b54;

  regReadStage #(
    .NumLanes(Lanes)
  ) dut_i (
    .clk        (clk),
    .rstN_i     (rstN),
    .issuePkt_i (issuePkt),
    .bypass_i   (bypass),
    .unmap_i    (unmap),
    .wakeup_i   (wakeup),
    .squash_i   (squash),
    .recover_i  (recover),
    .exception_i(exception),
    .outPkt_o   (outPkt),
    .phyRegRdy_o(phyRegRdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (10) @(negedge clk);
    rstN = 1'b1;
  end

  function automatic logic [31:0] nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] want);
    checkCount++;
    if (got !== want) begin
      errCount++;
      $display("Error %s: got 0x%0h, expected 0x%0h", name, got, want);
    end
  endtask

  task automatic checkOutputs();
    string pre;
    for (int l = 0; l < Lanes; l++) begin
      pre = $sformatf("outPkt_o[%0d].", l);
      checkValue({pre, "valid"}, 64'(outPkt[l].valid), 64'(expPkt[l].valid));
      if (haveExp) begin
        checkValue({pre, "branchMask"}, 64'(outPkt[l].branchMask), 64'(expPkt[l].branchMask));
        checkValue({pre, "src1Tag"}, 64'(outPkt[l].src1Tag), 64'(expPkt[l].src1Tag));
        checkValue({pre, "src2Tag"}, 64'(outPkt[l].src2Tag), 64'(expPkt[l].src2Tag));
        checkValue({pre, "destTag"}, 64'(outPkt[l].destTag), 64'(expPkt[l].destTag));
        checkValue({pre, "opcode"}, 64'(outPkt[l].opcode), 64'(expPkt[l].opcode));
        checkValue({pre, "immediate"}, 64'(outPkt[l].immediate), 64'(expPkt[l].immediate));
      end
      if (haveExp && expFull) begin
        checkValue({pre, "data1"}, 64'(outPkt[l].data1), 64'(expPkt[l].data1));
        checkValue({pre, "data2"}, 64'(outPkt[l].data2), 64'(expPkt[l].data2));
      end
    end
    checkValue("phyRegRdy_o", 64'(phyRegRdy), 64'(shadowRdy));
  endtask

  // check the previous step's results, then drive this step on the falling edge
  task automatic applyStep(input stepT s, input logic full);
    issueVecT           iss;
    bypassVecT          byp;
    unmapVecT           unm;
    wakeupVecT          wk;
    regReadPkg::squashT sq;
    logic [31:0]        r;
    @(negedge clk);
    checkOutputs();
    for (int l = 0; l < Lanes; l++) begin
      r = nextRand();
      iss[l].valid      = s.issV[l];
      iss[l].branchMask = s.bMask[4*l +: 4];
      iss[l].src1Tag    = regReadPkg::physTagT'(s.srcA + l);
      iss[l].src2Tag    = regReadPkg::physTagT'(s.srcB + l);
      iss[l].destTag    = r[5:0];
      iss[l].opcode     = r[15:8];
      iss[l].immediate  = r[31:16];
      byp[l].valid      = s.bypV[l];
      byp[l].tag        = regReadPkg::physTagT'(s.bypBase + l);
      byp[l].data       = nextRand();
      unm[l].valid      = s.unmV[l];
      unm[l].tag        = regReadPkg::physTagT'(s.unmBase + l);
      wk[l].valid       = s.wkV[l];
      wk[l].tag         = regReadPkg::physTagT'(s.wkBase + l);
    end
    sq.valid  = s.sqV;
    sq.ckptId = s.sqCk;
    expPkt    = expectPackets(iss, sq, byp);
    haveExp   = 1'b1;
    expFull   = full;
    updateModel(byp, s.recover, s.exception, unm, wk);
    issuePkt  = iss;
    bypass    = byp;
    unmap     = unm;
    wakeup    = wk;
    squash    = sq;
    recover   = s.recover;
    exception = s.exception;
  endtask

  initial begin
    stepT fill;
    int   waitCycles;
    issuePkt   = '0;
    bypass     = '0;
    unmap      = '0;
    wakeup     = '0;
    squash     = '0;
    recover    = 1'b0;
    exception  = 1'b0;
    expPkt     = '0;
    haveExp    = 1'b0;
    expFull    = 1'b0;
    errCount   = 0;
    checkCount = 0;
    shadowRdy  = readyAfterReset();
    waitCycles = 0;
    while (rstN !== 1'b1 && waitCycles < 100) begin
      @(negedge clk);
      waitCycles++;
    end
    if (rstN !== 1'b1) begin
      $display("reset was still active after %0d cycles", waitCycles);
      $display("TEST FAIL");
    end else begin
      // write every physical register once so that later reads are defined
      for (int i = 0; i < regReadPkg::PhysRegs / Lanes; i++) begin
        fill         = '0;
        fill.bypV    = 4'hf;
        fill.bypBase = 6'(i * Lanes);
        applyStep(fill, 1'b0);
      end
      for (int i = 0; i < NumSteps; i++) begin
        applyStep(Steps[i], 1'b1);
      end
      @(negedge clk);
      checkOutputs();
      $display("%0d checks, %0d errors", checkCount, errCount);
      if (errCount == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire
